// ==== tb.f ====
source/mips_pkg.sv
source/instr_decoder.sv
source/reg_file.sv
source/exec_unit.sv
source/pc_unit.sv
source/mips_core.sv
testbench/tb_checker.sv
testbench/tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps --top-module tb_top -f tb.f -o sim_tb \
    > build.log 2>&1 \
    && ./obj_dir/sim_tb 2>&1 | tee sim.log \
    && ! grep -q "Simulation FAILED" sim.log \
    && echo "run.sh: pass" \
    || { echo "run.sh: fail (see build.log and sim.log)"; exit 1; }

// ==== testbench/tb_top.sv ====
`timescale 1ns/10ps

module tb_top import mips_pkg::*; ();

    localparam logic [31:0] reset_pc = 32'h0000_0200;
    localparam int base = 128;  // Word index of reset_pc
    localparam int prog_len = 128;
    localparam int cycle_limit = 4 * (prog_len + 20) * 2;

    logic        clk;
    logic        rst_n;
    logic [31:0] instr;
    logic [31:0] dmem_rdata;
    logic [31:0] imem_addr;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_we;
    logic        dmem_re;
    logic [31:0] imem [1024];
    logic [31:0] dmem [256];
    logic [5:0]  r_fns [8] = '{fn_addu, fn_subu, fn_and, fn_or, fn_xor, fn_nor, fn_slt, fn_sltu};
    logic [5:0]  i_ops [6] = '{op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori};
    logic [5:0]  s_fns [3] = '{fn_sll, fn_srl, fn_sra};
    logic [5:0]  b_ops [6] = '{op_beq, op_bne, op_blez, op_bgtz, op_regimm, op_regimm};
    integer      seed = 32'h4a0f7053;
    int          pos;
    int          cycles = 0;
    int          errors;
    int          checks;

    mips_core #(.RESET_PC(reset_pc)) UUT (
        .clk(clk), .rst_n(rst_n), .instr(instr), .dmem_rdata(dmem_rdata),
        .imem_addr(imem_addr), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
        .dmem_we(dmem_we), .dmem_re(dmem_re)
    );

    tb_checker #(.RESET_PC(reset_pc)) u_checker (
        .clk(clk), .rst_n(rst_n), .instr(instr), .dmem_rdata(dmem_rdata),
        .imem_addr(imem_addr), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
        .dmem_we(dmem_we), .dmem_re(dmem_re), .errors(errors), .checks(checks)
    );

    always #2 clk = ~clk;

    assign instr      = imem[imem_addr[11:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    always @(posedge clk) begin
        if (dmem_we) begin
            dmem[dmem_addr[9:2]] <= dmem_wdata;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: program never reached end loop");
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic int rand_below(input int n);
        rand_below = ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    function automatic logic [4:0] rand_reg();
        rand_reg = 5'(1 + rand_below(8));  // r1..r8 only
    endfunction

    function automatic logic [15:0] data_off();
        data_off = 16'(rand_below(256) * 4);
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        i_word = {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] r_word(input logic [5:0] fn, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [4:0] rd,
                                           input logic [4:0] sa);
        r_word = {op_special, rs, rt, rd, sa, fn};
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[10'(pos)] = word;
        pos++;
    endtask

    task automatic store_reg(input logic [4:0] r);
        emit(i_word(op_sw, 5'd0, r, data_off()));
    endtask

    task automatic alu_op(output logic [4:0] dst);
        int kind;
        kind = rand_below(3);
        dst = rand_reg();
        case (kind)
            0: emit(r_word(r_fns[3'(rand_below(8))], rand_reg(), rand_reg(), dst, 5'd0));
            1: emit(i_word(i_ops[3'(rand_below(6))], rand_reg(), dst, 16'($random(seed))));
            default: emit(r_word(s_fns[2'(rand_below(3))], 5'd0, rand_reg(), dst,
                                 5'(rand_below(32))));
        endcase
    endtask

    task automatic data_chunk(input int test);
        logic [4:0] d;
        int pick;
        pick = rand_below(4);
        if (test == 2 && pick < 2) begin
            d = rand_reg();
            emit(i_word(op_lw, 5'd0, d, data_off()));
            if (pick == 1) begin
                d = rand_reg();
            end
        end else if (test == 4 && pick < 3) begin
            d = 5'd0;  // Writes aimed at r0
            case (pick)
                0: emit(i_word(op_addiu, rand_reg(), 5'd0, 16'($random(seed))));
                1: emit(r_word(fn_or, rand_reg(), rand_reg(), 5'd0, 5'd0));
                default: emit(i_word(op_lw, 5'd0, 5'd0, data_off()));
            endcase
        end else begin
            alu_op(d);
        end
        store_reg(d);
    endtask

    // Forward branch or jump over 1..3 fillers
    task automatic flow_chunk();
        logic [4:0] d;
        logic [4:0] rs;
        logic [4:0] rt;
        int kind;
        int skip;
        int b;
        kind = rand_below(6);
        skip = 1 + rand_below(3);
        rs = rand_reg();
        case (kind)
            0: begin
                b = rand_below(6);
                rt = (rand_below(2) == 0) ? rs : rand_reg();  // Equal half the time
                if (b >= 2) begin
                    rt = 5'(b == 5);
                end
                emit(i_word(b_ops[3'(b)], rs, rt, 16'(skip)));
            end
            1, 2: emit({(kind == 1) ? op_j : op_jal, 26'(pos + 1 + skip)});
            3, 4: begin
                emit(i_word(op_ori, 5'd0, 5'd9, 16'((pos + 2 + skip) * 4)));
                emit(r_word((kind == 3) ? fn_jr : fn_jalr, 5'd9, 5'd0,
                            (kind == 3) ? 5'd0 : rand_reg(), 5'd0));  // jalr links r31
            end
            default: ;
        endcase
        repeat (skip) alu_op(d);
        store_reg((kind == 2 || kind == 4) ? 5'd31 : d);
    endtask

    task automatic make_program(input int test);
        logic [4:0] d;
        int body_end;
        body_end = base + prog_len - 9;
        pos = base;
        for (int k = 1; k <= 8; k++) begin
            emit(i_word(op_addiu, 5'd0, 5'(k), 16'($random(seed))));
        end
        while (pos < body_end - 6) begin
            if (test == 3) begin
                flow_chunk();
            end else begin
                data_chunk(test);
            end
        end
        while (pos < body_end) begin
            alu_op(d);
        end
        for (int k = 1; k <= 8; k++) begin
            store_reg(5'(k));
        end
        emit({op_j, 26'(pos)});  // End loop
    endtask

    task automatic run_test(input int test, input string name);
        @(negedge clk);
        rst_n = 1'b0;
        make_program(test);
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        if (test == 4) begin
            repeat (41) @(negedge clk);  // First reset cycle sees a store
            rst_n = 1'b0;  // Reset in the middle of the program
            repeat (4) @(negedge clk);
            rst_n = 1'b1;
        end
        @(negedge clk);
        while (instr !== {op_j, imem_addr[27:2]}) begin
            @(negedge clk);
        end
        $display("test %0d %s: end loop at %h, %0d errors so far", test, name, imem_addr,
                 errors);
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            imem[10'(i)] = {op_j, 26'(i)};  // Unused words jump to themselves
        end
        for (int i = 0; i < 256; i++) begin
            dmem[8'(i)] = {8'(i), 8'h5e, ~8'(i), 8'hd0};
        end
        run_test(1, "arithmetic, logic and shifts");
        run_test(2, "loads and stores");
        run_test(3, "branches and jumps");
        run_test(4, "register 0 and reset");
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== testbench/tb_checker.sv ====
`timescale 1ns/10ps

module tb_checker import mips_pkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] instr,
    input  logic [31:0] dmem_rdata,
    input  logic [31:0] imem_addr,
    input  logic [31:0] dmem_addr,
    input  logic [31:0] dmem_wdata,
    input  logic        dmem_we,
    input  logic        dmem_re,
    output int          errors,
    output int          checks
);

    logic [31:0] regs [32];
    logic [31:0] mem [256];
    logic [31:0] pc;  // Predicted PC

    initial begin
        errors = 0;
        checks = 0;
        pc = RESET_PC;
        for (int i = 0; i < 32; i++) begin
            regs[5'(i)] = 32'd0;
        end
        for (int i = 0; i < 256; i++) begin
            mem[8'(i)] = {8'(i), 8'h5e, ~8'(i), 8'hd0};  // Same fill as the data memory
        end
    end

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    // ISA behavior of the instruction on the bus
    task automatic execute();
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sa;
        logic [4:0]  dst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] se;
        logic [31:0] ze;
        logic [31:0] addr;
        logic [31:0] next;
        logic [31:0] val;
        logic        wen;
        logic        store;
        logic        load;
        op = instr[31:26];
        rs = instr[25:21];
        rt = instr[20:16];
        rd = instr[15:11];
        sa = instr[10:6];
        fn = instr[5:0];
        a = regs[rs];
        b = regs[rt];
        se = {{16{instr[15]}}, instr[15:0]};
        ze = {16'd0, instr[15:0]};
        addr = a + se;
        next = pc + 32'd4;
        dst = rt;
        val = 32'd0;
        wen = 1'b0;
        store = 1'b0;
        load = 1'b0;
        case (op)
            op_special: begin
                wen = 1'b1;
                dst = rd;
                case (fn)
                    fn_sll:  val = b << sa;
                    fn_srl:  val = b >> sa;
                    fn_sra:  val = $signed(b) >>> sa;
                    fn_addu: val = a + b;
                    fn_subu: val = a - b;
                    fn_and:  val = a & b;
                    fn_or:   val = a | b;
                    fn_xor:  val = a ^ b;
                    fn_nor:  val = ~(a | b);
                    fn_slt:  val = {31'd0, $signed(a) < $signed(b)};
                    fn_sltu: val = {31'd0, a < b};
                    fn_jalr: begin
                        dst = 5'd31;  // Link register whatever rd holds
                        val = pc + 32'd4;
                        next = a;
                    end
                    fn_jr: begin
                        wen = 1'b0;
                        next = a;
                    end
                    default: wen = 1'b0;
                endcase
            end
            op_addiu: {wen, val} = {1'b1, a + se};
            op_slti:  {wen, val} = {1'b1, 31'd0, $signed(a) < $signed(se)};
            op_sltiu: {wen, val} = {1'b1, 31'd0, a < se};
            op_andi:  {wen, val} = {1'b1, a & ze};
            op_ori:   {wen, val} = {1'b1, a | ze};
            op_xori:  {wen, val} = {1'b1, a ^ ze};
            op_lw:    {wen, load, val} = {2'b11, mem[addr[9:2]]};
            op_sw:    store = 1'b1;
            op_beq:    if (a == b) next = next + (se << 2);
            op_bne:    if (a != b) next = next + (se << 2);
            op_blez:   if ($signed(a) <= 0) next = next + (se << 2);
            op_bgtz:   if ($signed(a) > 0) next = next + (se << 2);
            op_regimm: if (a[31] != rt[0]) next = next + (se << 2);  // rt[0] picks bgez
            op_j:      next = {next[31:28], instr[25:0], 2'b00};
            op_jal: begin
                {wen, dst, val} = {1'b1, 5'd31, pc + 32'd4};
                next = {next[31:28], instr[25:0], 2'b00};
            end
            default: ;
        endcase
        compare("dmem_we", {31'd0, store}, {31'd0, dmem_we});
        compare("dmem_re", {31'd0, load}, {31'd0, dmem_re});
        if (store || load) begin
            compare("dmem_addr", addr, dmem_addr);
        end
        if (load) begin
            compare("dmem_rdata", mem[addr[9:2]], dmem_rdata);
        end
        if (store) begin
            compare("dmem_wdata", b, dmem_wdata);
            mem[addr[9:2]] = b;
        end
        if (wen && dst != 5'd0) begin
            regs[dst] = val;
        end
        pc = next;
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            pc = RESET_PC;
            compare("dmem_we", 32'd0, {31'd0, dmem_we});  // No store in reset
        end else begin
            compare("imem_addr", pc, imem_addr);
            execute();
        end
    end

endmodule

// ==== source/mips_core.sv ====
`timescale 1ns/10ps

module mips_core import mips_pkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] instr,
    input  logic [31:0] dmem_rdata,
    output logic [31:0] imem_addr,
    output logic [31:0] dmem_addr,
    output logic [31:0] dmem_wdata,
    output logic        dmem_we,
    output logic        dmem_re
);

    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  wr_addr;
    logic        reg_we;
    logic        use_imm;
    logic        imm_zero_ext;
    logic        mem_we;
    logic        mem_re;
    logic [1:0]  wb_sel;
    logic [1:0]  pc_sel;
    logic [1:0]  shift_type;
    logic [3:0]  alu_fn;
    logic [3:0]  branch_fn;
    logic [4:0]  sa;
    logic [15:0] imm;
    logic [25:0] iindex;
    logic [31:0] rs_val;
    logic [31:0] rt_val;
    logic [31:0] wr_data;
    logic [31:0] alu_result;
    logic [31:0] shift_result;
    logic [31:0] pc;
    logic [31:0] pc_plus4;

    instr_decoder u_decoder (
        .instr(instr), .rs(rs), .rt(rt), .wr_addr(wr_addr), .reg_we(reg_we),
        .use_imm(use_imm), .imm_zero_ext(imm_zero_ext), .mem_we(mem_we), .mem_re(mem_re),
        .wb_sel(wb_sel), .pc_sel(pc_sel), .shift_type(shift_type), .alu_fn(alu_fn),
        .branch_fn(branch_fn), .sa(sa), .imm(imm), .iindex(iindex)
    );

    reg_file u_regs (
        .clk(clk), .rst_n(rst_n), .rs(rs), .rt(rt), .wr_addr(wr_addr),
        .wr_data(wr_data), .we(reg_we), .rs_val(rs_val), .rt_val(rt_val)
    );

    exec_unit u_exec (
        .rs_val(rs_val), .rt_val(rt_val), .imm(imm), .sa(sa), .alu_fn(alu_fn),
        .use_imm(use_imm), .imm_zero_ext(imm_zero_ext), .shift_type(shift_type),
        .alu_result(alu_result), .shift_result(shift_result)
    );

    pc_unit #(.RESET_PC(RESET_PC)) u_pc (
        .clk(clk), .rst_n(rst_n), .rs_val(rs_val), .rt_val(rt_val), .imm(imm),
        .iindex(iindex), .branch_fn(branch_fn), .pc_sel(pc_sel), .pc(pc),
        .pc_plus4(pc_plus4)
    );

    always_comb begin
        case (wb_sel)
            wb_mem:   wr_data = dmem_rdata;
            wb_shift: wr_data = shift_result;
            wb_pc:    wr_data = pc_plus4;  // Link address
            default:  wr_data = alu_result;
        endcase
    end

    assign imem_addr  = pc;
    assign dmem_addr  = alu_result;
    assign dmem_wdata = rt_val;
    assign dmem_we    = mem_we && rst_n;  // No memory traffic in reset
    assign dmem_re    = mem_re && rst_n;

endmodule

// ==== source/pc_unit.sv ====
`timescale 1ns/10ps

module pc_unit import mips_pkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] rs_val,
    input  logic [31:0] rt_val,
    input  logic [15:0] imm,
    input  logic [25:0] iindex,
    input  logic [3:0]  branch_fn,
    input  logic [1:0]  pc_sel,
    output logic [31:0] pc,
    output logic [31:0] pc_plus4
);

    logic [31:0] branch_target;
    logic [31:0] next_pc;
    logic        taken;
    logic        rs_neg;
    logic        rs_zero;

    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};

    assign rs_neg  = rs_val[31];
    assign rs_zero = (rs_val == 32'd0);

    always_comb begin
        casez (branch_fn)
            4'b100?: taken = (rs_val == rt_val);  // beq
            4'b101?: taken = (rs_val != rt_val);  // bne
            4'b110?: taken = rs_neg || rs_zero;   // blez
            4'b111?: taken = !rs_neg && !rs_zero; // bgtz
            4'b0010: taken = rs_neg;              // bltz
            4'b0011: taken = !rs_neg;             // bgez
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (pc_sel)
            pc_reg:    next_pc = rs_val;
            pc_branch: next_pc = taken ? branch_target : pc_plus4;
            pc_jump:   next_pc = {pc_plus4[31:28], iindex, 2'b00};
            default:   next_pc = pc_plus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

endmodule

// ==== source/exec_unit.sv ====
`timescale 1ns/10ps

module exec_unit import mips_pkg::*; (
    input  logic [31:0] rs_val,
    input  logic [31:0] rt_val,
    input  logic [15:0] imm,
    input  logic [4:0]  sa,
    input  logic [3:0]  alu_fn,
    input  logic        use_imm,
    input  logic        imm_zero_ext,
    input  logic [1:0]  shift_type,
    output logic [31:0] alu_result,
    output logic [31:0] shift_result
);

    logic [31:0] imm_ext;
    logic [31:0] op_b;

    assign imm_ext = imm_zero_ext ? {16'd0, imm} : {{16{imm[15]}}, imm};
    assign op_b    = use_imm ? imm_ext : rt_val;

    always_comb begin
        case (alu_fn)
            alu_addu: alu_result = rs_val + op_b;
            alu_subu: alu_result = rs_val - op_b;
            alu_and:  alu_result = rs_val & op_b;
            alu_or:   alu_result = rs_val | op_b;
            alu_xor:  alu_result = rs_val ^ op_b;
            alu_nor:  alu_result = ~(rs_val | op_b);
            alu_slt:  alu_result = {31'd0, $signed(rs_val) < $signed(op_b)};
            alu_sltu: alu_result = {31'd0, rs_val < op_b};
            default:  alu_result = rs_val + op_b;
        endcase
    end

    // Fixed amount from the sa field only
    always_comb begin
        case (shift_type)
            sh_srl:  shift_result = rt_val >> sa;
            sh_sra:  shift_result = $unsigned($signed(rt_val) >>> sa);
            default: shift_result = rt_val << sa;
        endcase
    end

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/10ps

module reg_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs,
    input  logic [4:0]  rt,
    input  logic [4:0]  wr_addr,
    input  logic [31:0] wr_data,
    input  logic        we,
    output logic [31:0] rs_val,
    output logic [31:0] rt_val
);

    logic [31:0] regs [32];

    // Writes land on the edge that ends the instruction
    always_ff @(posedge clk) begin
        if (rst_n && we && wr_addr != 5'd0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs_val = (rs == 5'd0) ? 32'd0 : regs[rs];
    assign rt_val = (rt == 5'd0) ? 32'd0 : regs[rt];

endmodule

// ==== source/instr_decoder.sv ====
`timescale 1ns/10ps

module instr_decoder import mips_pkg::*; (
    input  logic [31:0] instr,
    output logic [4:0]  rs,
    output logic [4:0]  rt,
    output logic [4:0]  wr_addr,
    output logic        reg_we,
    output logic        use_imm,
    output logic        imm_zero_ext,
    output logic        mem_we,
    output logic        mem_re,
    output logic [1:0]  wb_sel,
    output logic [1:0]  pc_sel,
    output logic [1:0]  shift_type,
    output logic [3:0]  alu_fn,
    output logic [3:0]  branch_fn,
    output logic [4:0]  sa,
    output logic [15:0] imm,
    output logic [25:0] iindex
);

    localparam logic [1:0] type_i = 2'b00;
    localparam logic [1:0] type_j = 2'b01;
    localparam logic [1:0] type_r = 2'b10;

    logic [5:0] opc;
    logic [5:0] fun;
    logic [4:0] rd;
    logic [1:0] itype;
    logic       is_link;

    function automatic logic [1:0] instr_type(input logic [5:0] op);
        case (op)
            op_special:   instr_type = type_r;
            op_j, op_jal: instr_type = type_j;
            default:      instr_type = type_i;
        endcase
    endfunction

    function automatic logic is_written(input logic [5:0] op, input logic [5:0] fn);
        case (op)
            op_addiu, op_slti, op_sltiu,
            op_andi, op_ori, op_xori,
            op_lw, op_jal: is_written = 1'b1;
            op_special:    is_written = (fn != fn_jr);
            default:       is_written = 1'b0;
        endcase
    endfunction

    function automatic logic [1:0] where_from(input logic [1:0] t, input logic [5:0] op,
                                              input logic [5:0] fn);
        case (t)
            type_r: begin
                case (fn)
                    fn_jalr:                where_from = wb_pc;
                    fn_sll, fn_srl, fn_sra: where_from = wb_shift;
                    default:                where_from = wb_alu;
                endcase
            end
            type_i: begin
                case (op)
                    op_lw:   where_from = wb_mem;
                    op_addiu, op_slti, op_sltiu,
                    op_andi, op_ori, op_xori: where_from = wb_alu;
                    default: where_from = wb_pc;  // Branches are never written
                endcase
            end
            default: where_from = wb_pc;  // jal
        endcase
    endfunction

    function automatic logic [1:0] pc_select(input logic [5:0] op, input logic [5:0] fn);
        case (op)
            op_special: pc_select = (fn == fn_jr || fn == fn_jalr) ? pc_reg : pc_seq;
            op_beq, op_bne, op_blez,
            op_bgtz, op_regimm: pc_select = pc_branch;
            op_j, op_jal:       pc_select = pc_jump;
            default:            pc_select = pc_seq;
        endcase
    endfunction

    assign opc    = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign sa     = instr[10:6];
    assign fun    = instr[5:0];
    assign imm    = instr[15:0];
    assign iindex = instr[25:0];

    assign itype        = instr_type(opc);
    assign reg_we       = is_written(opc, fun);
    assign wb_sel       = where_from(itype, opc, fun);
    assign pc_sel       = pc_select(opc, fun);
    assign use_imm      = (itype != type_r);
    assign imm_zero_ext = (opc == op_andi) || (opc == op_ori) || (opc == op_xori);
    assign mem_we       = (opc == op_sw);
    assign mem_re       = (opc == op_lw);
    assign branch_fn    = {instr[28:26], instr[16]};  // bit 16 splits bltz from bgez

    assign is_link = (opc == op_jal) || (opc == op_special && fun == fn_jalr);
    assign wr_addr = is_link ? 5'd31 : (itype == type_r) ? rd : rt;

    always_comb begin
        if (mem_we || mem_re)
            alu_fn = alu_addu;  // Address add
        else if (itype == type_r)
            alu_fn = fun[3:0];
        else
            alu_fn = {~instr[28] & instr[27], instr[28:26]};
    end

    always_comb begin
        case (fun)
            fn_srl:  shift_type = sh_srl;
            fn_sra:  shift_type = sh_sra;
            default: shift_type = sh_sll;
        endcase
    end

endmodule

// ==== source/mips_pkg.sv ====
package mips_pkg;

    // Major opcodes in instr[31:26]
    localparam logic [5:0] op_special = 6'b000000;
    localparam logic [5:0] op_regimm  = 6'b000001;  // bltz, bgez
    localparam logic [5:0] op_j       = 6'b000010;
    localparam logic [5:0] op_jal     = 6'b000011;
    localparam logic [5:0] op_beq     = 6'b000100;
    localparam logic [5:0] op_bne     = 6'b000101;
    localparam logic [5:0] op_blez    = 6'b000110;
    localparam logic [5:0] op_bgtz    = 6'b000111;
    localparam logic [5:0] op_addiu   = 6'b001001;
    localparam logic [5:0] op_slti    = 6'b001010;
    localparam logic [5:0] op_sltiu   = 6'b001011;
    localparam logic [5:0] op_andi    = 6'b001100;
    localparam logic [5:0] op_ori     = 6'b001101;
    localparam logic [5:0] op_xori    = 6'b001110;
    localparam logic [5:0] op_lw      = 6'b100011;
    localparam logic [5:0] op_sw      = 6'b101011;

    // Function field of op_special in instr[5:0]
    localparam logic [5:0] fn_sll  = 6'b000000;
    localparam logic [5:0] fn_srl  = 6'b000010;
    localparam logic [5:0] fn_sra  = 6'b000011;
    localparam logic [5:0] fn_jr   = 6'b001000;
    localparam logic [5:0] fn_jalr = 6'b001001;
    localparam logic [5:0] fn_addu = 6'b100001;
    localparam logic [5:0] fn_subu = 6'b100011;
    localparam logic [5:0] fn_and  = 6'b100100;
    localparam logic [5:0] fn_or   = 6'b100101;
    localparam logic [5:0] fn_xor  = 6'b100110;
    localparam logic [5:0] fn_nor  = 6'b100111;
    localparam logic [5:0] fn_slt  = 6'b101010;
    localparam logic [5:0] fn_sltu = 6'b101011;

    // ALU codes equal the low nibble of the function field
    localparam logic [3:0] alu_addu = 4'b0001;
    localparam logic [3:0] alu_subu = 4'b0011;
    localparam logic [3:0] alu_and  = 4'b0100;
    localparam logic [3:0] alu_or   = 4'b0101;
    localparam logic [3:0] alu_xor  = 4'b0110;
    localparam logic [3:0] alu_nor  = 4'b0111;
    localparam logic [3:0] alu_slt  = 4'b1010;
    localparam logic [3:0] alu_sltu = 4'b1011;

    localparam logic [1:0] wb_alu   = 2'b00;
    localparam logic [1:0] wb_mem   = 2'b01;
    localparam logic [1:0] wb_shift = 2'b10;
    localparam logic [1:0] wb_pc    = 2'b11;  // Link address

    localparam logic [1:0] pc_reg    = 2'b00;  // jr, jalr
    localparam logic [1:0] pc_branch = 2'b01;
    localparam logic [1:0] pc_jump   = 2'b10;
    localparam logic [1:0] pc_seq    = 2'b11;

    localparam logic [1:0] sh_sll = 2'b00;
    localparam logic [1:0] sh_srl = 2'b01;
    localparam logic [1:0] sh_sra = 2'b10;

endpackage
